//--- btb_pkg.sv
`default_nettype none

package btb_pkg;

    // buffer geometry
    localparam int BTB_ENTRIES = 16;
    // fetch line size in bytes
    localparam int LINE_BYTES = 16;
    // byte offset bits inside a fetch line
    localparam int LINE_OFS_W = $clog2(LINE_BYTES);

    // 32-bit instruction pointer
    typedef logic [31:0] eip_t;
    // line address, eip without the byte offset
    typedef logic [31-LINE_OFS_W:0] fip_t;
    // one bit per buffer entry
    typedef logic [BTB_ENTRIES-1:0] entry_sel_t;

    // fetch start after reset
    localparam eip_t RESET_EIP = 32'h0000_FFF0;
    // line of the reset vector
    localparam fip_t RESET_FIP = RESET_EIP[31:LINE_OFS_W];

    // resolved branch from writeback
    typedef struct packed {
        logic valid;
        eip_t branch_eip;
        eip_t target_eip;
        fip_t fip_e;
        fip_t fip_o;
    } btb_upd_t;

    // lookup result for the current fetch eip
    typedef struct packed {
        logic hit;
        eip_t target_eip;
        fip_t fip_e;
        fip_t fip_o;
    } btb_pred_t;

    // mispredict redirect from writeback
    typedef struct packed {
        logic valid;
        eip_t eip;
    } wb_redirect_t;

endpackage

`default_nettype wire

//--- btb_victim_sel.sv
`timescale 1ns/1ps
`default_nettype none

module btb_victim_sel
    import btb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       upd_valid,
    input  entry_sel_t upd_match,
    output entry_sel_t wr_sel
);

    // one-hot round-robin pointer, next entry to replace
    entry_sel_t ring;
    // update branch already held in some entry
    logic       upd_hit;

    assign upd_hit = |upd_match;

    // write target for this cycle
    always_comb begin
        if (!upd_valid) begin
            // no update, nothing written
            wr_sel = '0;
        end else if (upd_hit) begin
            // rewrite the existing entry in place
            wr_sel = upd_match;
        end else begin
            // new branch goes to the victim
            wr_sel = ring;
        end
    end

    // ring moves only when a victim was actually consumed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // start at entry 0
            ring <= entry_sel_t'(1);
        end else if (upd_valid && !upd_hit) begin
            // rotate left by one, msb wraps to entry 0
            ring <= {ring[BTB_ENTRIES-2:0], ring[BTB_ENTRIES-1]};
        end
    end

endmodule

`default_nettype wire

//--- branch_target_buff.sv
`timescale 1ns/1ps
`default_nettype none

module branch_target_buff
    import btb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  eip_t       fetch_eip,
    input  btb_upd_t   upd,
    input  entry_sel_t wr_sel,
    output entry_sel_t upd_match,
    output btb_pred_t  pred
);

    // one stored branch
    typedef struct packed {
        eip_t tag;
        eip_t target_eip;
        fip_t fip_e;
        fip_t fip_o;
    } btb_entry_t;

    // per entry valid bits
    entry_sel_t valid_q;
    // entry payload, tag is the full branch eip
    btb_entry_t entries [BTB_ENTRIES];

    // valid entries whose tag equals the fetch eip
    entry_sel_t look_match;

    // selected fields of the hitting entry
    eip_t sel_target;
    fip_t sel_fip_e;
    fip_t sel_fip_o;

    // valid bits, set on write, cleared only by reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_q | wr_sel;
        end
    end

    // payload load, every selected entry takes the update fields
    always_ff @(posedge clk) begin
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            if (wr_sel[i]) begin
                entries[i].tag        <= upd.branch_eip;
                entries[i].target_eip <= upd.target_eip;
                entries[i].fip_e      <= upd.fip_e;
                entries[i].fip_o      <= upd.fip_o;
            end
        end
    end

    // tag compares, lookup and update side
    // both see the old contents during a write cycle
    always_comb begin
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            look_match[i] = valid_q[i] && (entries[i].tag == fetch_eip);
            upd_match[i]  = valid_q[i] && (entries[i].tag == upd.branch_eip);
        end
    end

    // one-hot and-or select
    // at most one entry matches, so the or acts as a mux
    always_comb begin
        sel_target = '0;
        sel_fip_e  = '0;
        sel_fip_o  = '0;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            sel_target = sel_target | ({$bits(eip_t){look_match[i]}} & entries[i].target_eip);
            sel_fip_e  = sel_fip_e | ({$bits(fip_t){look_match[i]}} & entries[i].fip_e);
            sel_fip_o  = sel_fip_o | ({$bits(fip_t){look_match[i]}} & entries[i].fip_o);
        end
    end

    // lookup result
    // zero payload on a miss
    always_comb begin
        pred.hit        = |look_match;
        pred.target_eip = sel_target;
        pred.fip_e      = sel_fip_e;
        pred.fip_o      = sel_fip_o;
    end

endmodule

`default_nettype wire

//--- fetch_redirect.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_redirect
    import btb_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         stall,
    input  wb_redirect_t redirect,
    input  btb_pred_t    pred,
    output eip_t         fetch_eip,
    output fip_t         fip_e,
    output fip_t         fip_o,
    output logic         pred_hit
);

    // registered fetch state
    typedef struct packed {
        eip_t eip;
        fip_t fip_e;
        fip_t fip_o;
        logic hit;
    } fetch_state_t;

    fetch_state_t state_q;
    fetch_state_t state_d;

    // line of the redirect target
    fip_t redir_line;
    // next sequential line start
    eip_t seq_eip;

    assign redir_line = redirect.eip[31:LINE_OFS_W];
    // drop the byte offset, step one line
    assign seq_eip    = {state_q.eip[31:LINE_OFS_W], {LINE_OFS_W{1'b0}}} + eip_t'(LINE_BYTES);

    // next state, redirect over stall over hit over sequential
    always_comb begin
        if (redirect.valid) begin
            state_d.eip   = redirect.eip;
            state_d.fip_e = redir_line;
            state_d.fip_o = redir_line + fip_t'(1);
            state_d.hit   = 1'b0;
        end else if (stall) begin
            // hold everything
            state_d = state_q;
        end else if (pred.hit) begin
            state_d.eip   = pred.target_eip;
            state_d.fip_e = pred.fip_e;
            state_d.fip_o = pred.fip_o;
            state_d.hit   = 1'b1;
        end else begin
            state_d.eip   = seq_eip;
            state_d.fip_e = state_q.fip_e + fip_t'(1);
            state_d.fip_o = state_q.fip_o + fip_t'(1);
            state_d.hit   = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // reset vector, even line and the one after it
            state_q.eip   <= RESET_EIP;
            state_q.fip_e <= RESET_FIP;
            state_q.fip_o <= RESET_FIP + fip_t'(1);
            state_q.hit   <= 1'b0;
        end else begin
            state_q <= state_d;
        end
    end

    assign fetch_eip = state_q.eip;
    assign fip_e     = state_q.fip_e;
    assign fip_o     = state_q.fip_o;
    assign pred_hit  = state_q.hit;

endmodule

`default_nettype wire

//--- btb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module btb_fetch_top
    import btb_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  btb_upd_t     upd,
    input  wb_redirect_t redirect,
    input  logic         stall,
    output eip_t         fetch_eip,
    output fip_t         fip_e,
    output fip_t         fip_o,
    output logic         pred_hit
);

    // btb tag matches for the update eip
    entry_sel_t upd_match;
    // entry written this cycle
    entry_sel_t wr_sel;
    // lookup result for fetch_eip
    btb_pred_t  pred;

    // decode, choose the write entry
    btb_victim_sel u_victim_sel (
        .clk       (clk),
        .rst_n     (rst_n),
        .upd_valid (upd.valid),
        .upd_match (upd_match),
        .wr_sel    (wr_sel)
    );

    // execute, storage and lookup
    branch_target_buff u_btb (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_eip (fetch_eip),
        .upd       (upd),
        .wr_sel    (wr_sel),
        .upd_match (upd_match),
        .pred      (pred)
    );

    // result, next fetch address
    fetch_redirect u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .redirect  (redirect),
        .pred      (pred),
        .fetch_eip (fetch_eip),
        .fip_e     (fip_e),
        .fip_o     (fip_o),
        .pred_hit  (pred_hit)
    );

endmodule

`default_nettype wire

//--- tb_btb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_btb_fetch
    import btb_pkg::*;
();

    localparam int CLK_HALF   = 2;
    localparam int RST_CYCLES = 8;

    // fixed branches for the directed part
    localparam eip_t X_EIP  = 32'h0001_2344;
    localparam eip_t X_TGT  = 32'h0004_0008;
    localparam eip_t X_TGT2 = 32'h0007_7730;
    localparam eip_t Y_EIP  = 32'h0002_0010;
    localparam eip_t Y_TGT  = 32'h0009_1004;

    localparam btb_upd_t     NO_UPD   = '0;
    localparam wb_redirect_t NO_REDIR = '0;

    // one table row, inputs for one cycle
    typedef struct packed {
        btb_upd_t     upd;
        wb_redirect_t redirect;
        logic         stall;
        logic         chk;
    } row_t;

    logic         clk;
    logic         rst_n;
    btb_upd_t     upd;
    wb_redirect_t redirect;
    logic         stall;
    eip_t         fetch_eip;
    fip_t         fip_e;
    fip_t         fip_o;
    logic         pred_hit;

    row_t  rows [$];
    string row_names [$];

    // reference buffer contents
    logic m_valid [BTB_ENTRIES];
    eip_t m_tag [BTB_ENTRIES];
    eip_t m_tgt [BTB_ENTRIES];
    fip_t m_fe [BTB_ENTRIES];
    fip_t m_fo [BTB_ENTRIES];
    int   m_ring;

    // expected fetch state
    eip_t exp_eip;
    fip_t exp_fe;
    fip_t exp_fo;
    logic exp_hit;

    logic [15:0] lfsr_q;
    int          errors;
    int          checks;
    int          cycle_count;
    int          cycle_limit;

    btb_fetch_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .upd       (upd),
        .redirect  (redirect),
        .stall     (stall),
        .fetch_eip (fetch_eip),
        .fip_e     (fip_e),
        .fip_o     (fip_o),
        .pred_hit  (pred_hit)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // hard stop if the run overruns
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // 16-bit fibonacci lfsr, taps 16 14 13 11, one output bit per step
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic eip_t rand_eip();
        eip_t e;
        e = '0;
        for (int b = 0; b < 32; b++) begin
            e = {e[30:0], lfsr_bit()};
        end
        return e;
    endfunction

    // stored pointers: even line of the target, odd line two further on
    function automatic btb_upd_t make_upd(input eip_t br, input eip_t tgt);
        btb_upd_t u;
        u.valid      = 1'b1;
        u.branch_eip = br;
        u.target_eip = tgt;
        u.fip_e      = fip_t'(tgt / LINE_BYTES);
        u.fip_o      = fip_t'(tgt / LINE_BYTES) + fip_t'(2);
        return u;
    endfunction

    function automatic wb_redirect_t make_redir(input eip_t e);
        wb_redirect_t r;
        r.valid = 1'b1;
        r.eip   = e;
        return r;
    endfunction

    task automatic add_row(input string name, input btb_upd_t u, input wb_redirect_t r,
                           input logic st, input logic chk);
        row_t row;
        row.upd      = u;
        row.redirect = r;
        row.stall    = st;
        row.chk      = chk;
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    task automatic build_table();
        eip_t burst [17];
        // sequential fetch from the reset vector
        for (int i = 0; i < 4; i++) begin
            add_row("seq_advance", NO_UPD, NO_REDIR, 1'b0, 1'b1);
        end
        // update while x is being looked up, then hit on the next visit
        add_row("redirect_x", NO_UPD, make_redir(X_EIP), 1'b0, 1'b1);
        add_row("upd_same_cycle", make_upd(X_EIP, X_TGT), NO_REDIR, 1'b0, 1'b1);
        add_row("redirect_x_again", NO_UPD, make_redir(X_EIP), 1'b0, 1'b1);
        add_row("hit_x", NO_UPD, NO_REDIR, 1'b0, 1'b1);
        // rewrite of x in place, y must survive
        add_row("upd_y", make_upd(Y_EIP, Y_TGT), NO_REDIR, 1'b0, 1'b1);
        add_row("rewrite_x", make_upd(X_EIP, X_TGT2), NO_REDIR, 1'b0, 1'b1);
        add_row("redirect_x_new", NO_UPD, make_redir(X_EIP), 1'b0, 1'b1);
        add_row("hit_x_new", NO_UPD, NO_REDIR, 1'b0, 1'b1);
        add_row("redirect_y", NO_UPD, make_redir(Y_EIP), 1'b0, 1'b1);
        add_row("hit_y", NO_UPD, NO_REDIR, 1'b0, 1'b1);
        // seventeen new branches wrap the ring
        for (int i = 0; i < 17; i++) begin
            burst[i] = rand_eip();
            add_row("burst_upd", make_upd(burst[i], rand_eip()), NO_REDIR, 1'b0, 1'b0);
        end
        add_row("redirect_first", NO_UPD, make_redir(burst[0]), 1'b0, 1'b1);
        add_row("evicted_miss", NO_UPD, NO_REDIR, 1'b0, 1'b1);
        for (int i = 1; i < 17; i++) begin
            add_row("redirect_recent", NO_UPD, make_redir(burst[i]), 1'b0, 1'b1);
            add_row("recent_hit", NO_UPD, NO_REDIR, 1'b0, 1'b1);
        end
        // stall holds even over a hit, redirect still wins
        add_row("pre_stall", NO_UPD, make_redir(burst[16]), 1'b0, 1'b1);
        for (int i = 0; i < 3; i++) begin
            add_row("stall_hold", NO_UPD, NO_REDIR, 1'b1, 1'b1);
        end
        add_row("stall_redirect", NO_UPD, make_redir(Y_EIP), 1'b1, 1'b1);
        add_row("stall_hold_after", NO_UPD, NO_REDIR, 1'b1, 1'b1);
        add_row("stall_hold_after", NO_UPD, NO_REDIR, 1'b1, 1'b1);
        add_row("stall_release", NO_UPD, NO_REDIR, 1'b0, 1'b1);
        add_row("stall_release", NO_UPD, NO_REDIR, 1'b0, 1'b1);
    endtask

    // reference step, lookup on old contents then write
    task automatic model_step(input row_t r);
        int hit_idx;
        int wr_idx;
        hit_idx = -1;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            if (m_valid[i] && m_tag[i] == exp_eip) begin
                hit_idx = i;
            end
        end
        if (r.redirect.valid) begin
            exp_eip = r.redirect.eip;
            exp_fe  = fip_t'(r.redirect.eip / LINE_BYTES);
            exp_fo  = exp_fe + fip_t'(1);
            exp_hit = 1'b0;
        end else if (r.stall) begin
            // nothing moves
        end else if (hit_idx >= 0) begin
            exp_eip = m_tgt[hit_idx];
            exp_fe  = m_fe[hit_idx];
            exp_fo  = m_fo[hit_idx];
            exp_hit = 1'b1;
        end else begin
            exp_eip = (exp_eip / LINE_BYTES) * LINE_BYTES + LINE_BYTES;
            exp_fe  = exp_fe + fip_t'(1);
            exp_fo  = exp_fo + fip_t'(1);
            exp_hit = 1'b0;
        end
        if (r.upd.valid) begin
            wr_idx = -1;
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                if (m_valid[i] && m_tag[i] == r.upd.branch_eip) begin
                    wr_idx = i;
                end
            end
            // new branch takes the ring slot
            if (wr_idx < 0) begin
                wr_idx = m_ring;
                m_ring = (m_ring + 1) % BTB_ENTRIES;
            end
            m_valid[wr_idx] = 1'b1;
            m_tag[wr_idx]   = r.upd.branch_eip;
            m_tgt[wr_idx]   = r.upd.target_eip;
            m_fe[wr_idx]    = r.upd.fip_e;
            m_fo[wr_idx]    = r.upd.fip_o;
        end
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", name, field, expected, actual);
        end
    endtask

    task automatic check_state(input string name);
        check_value(name, "fetch_eip", exp_eip, fetch_eip);
        check_value(name, "fip_e", 32'(exp_fe), 32'(fip_e));
        check_value(name, "fip_o", 32'(exp_fo), 32'(fip_o));
        check_value(name, "pred_hit", 32'(exp_hit), 32'(pred_hit));
    endtask

    initial begin
        rst_n       = 1'b0;
        upd         = '0;
        redirect    = '0;
        stall       = 1'b0;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        lfsr_q      = 16'd63169;
        build_table();
        cycle_limit = RST_CYCLES + 2 * rows.size() + 20;
        // reset state of the reference
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        m_ring  = 0;
        exp_eip = RESET_EIP;
        exp_fe  = fip_t'(RESET_EIP / LINE_BYTES);
        exp_fo  = exp_fe + fip_t'(1);
        exp_hit = 1'b0;
        repeat (RST_CYCLES - 1) @(posedge clk);
        // row k drives cycle k, its result shows after the next edge
        for (int k = 0; k <= rows.size(); k++) begin
            @(posedge clk);
            // release lands on the eighth edge together with the first row
            rst_n <= 1'b1;
            if (k < rows.size()) begin
                upd      <= rows[k].upd;
                redirect <= rows[k].redirect;
                stall    <= rows[k].stall;
            end else begin
                upd      <= NO_UPD;
                redirect <= NO_REDIR;
                stall    <= 1'b0;
            end
            @(negedge clk);
            if (k == 0) begin
                check_state("after_reset");
            end else if (rows[k-1].chk) begin
                check_state(row_names[k-1]);
            end
            if (k < rows.size()) begin
                model_step(rows[k]);
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- btb_fetch.f
btb_pkg.sv
btb_victim_sel.sv
branch_target_buff.sv
fetch_redirect.sv
btb_fetch_top.sv
tb_btb_fetch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the btb_fetch testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_btb_fetch \
    -f btb_fetch.f \
    -o sim_btb_fetch

out="$(./obj_dir/sim_btb_fetch)"
echo "$out"

# pass only when the testbench printed its pass line
if grep -qxF '>>> PASS' <<< "$out"; then
    exit 0
else
    exit 1
fi
